//--- design/local_mem_pkg.sv
// Shared widths, stage counts and command types for the local memory path.
// All timing is on one clock; bursts are limited to MEM_MAX_BURST beats.
// N_CMD_REG_STAGES may be set to zero, one or more without other changes.

`default_nettype none

package local_mem_pkg;

    // ============================================================
    // Widths
    // ============================================================

    // Word address width, 1024 words of memory
    localparam int MEM_ADDR_W = 10;

    // Data word width in bits
    localparam int MEM_DATA_W = 64;

    // One byte enable bit per data byte
    localparam int MEM_BE_W = MEM_DATA_W / 8;

    // Burst count width; the field can hold more than the legal maximum
    localparam int MEM_BURST_W = 4;

    // Largest legal burst, larger requests are clamped by the bank
    localparam int MEM_MAX_BURST = 8;

    // ============================================================
    // Pipeline depths
    // ============================================================

    // Timing register stages between the AFU port and the bank
    localparam int N_CMD_REG_STAGES = 2;

    // Cycles from a read issuing inside the bank to readdatavalid
    localparam int MEM_READ_LATENCY = 2;

    // ============================================================
    // Types
    // ============================================================

    typedef logic [MEM_ADDR_W-1:0]  mem_addr_t;
    typedef logic [MEM_DATA_W-1:0]  mem_data_t;
    typedef logic [MEM_BE_W-1:0]    mem_be_t;
    typedef logic [MEM_BURST_W-1:0] mem_burst_t;

    // One command beat on the Avalon-MM command path.
    // A beat is valid when read or write is set, never both.
    // Only the first beat of a write burst carries address and count
    typedef struct packed {
        logic       read;
        logic       write;
        mem_addr_t  address;
        mem_burst_t burstcount;
        mem_data_t  writedata;
        mem_be_t    byteenable;
    } avl_cmd_t;

    // Bank burst sequencer states
    typedef enum logic [1:0] {
        BANK_IDLE,
        BANK_WR_BURST,
        BANK_RD_BURST
    } bank_state_t;

endpackage

`default_nettype wire

//--- design/avalon_cmd_reg_stage.sv
// One timing register stage on the Avalon command path.
// Holds at most two beats: a main entry and a skid entry.
// Upstream waitrequest is a flop, so no combinational path crosses the stage.

`default_nettype none

module avalon_cmd_reg_stage (
    input  logic                    tgt_mem_afu_clk,
    input  logic                    rst_n,

    // Upstream side, toward the AFU
    input  local_mem_pkg::avl_cmd_t in_cmd,
    output logic                    in_waitrequest,

    // Downstream side, toward the bank
    output local_mem_pkg::avl_cmd_t out_cmd,
    input  logic                    out_waitrequest
);

    // Entry payloads carry no reset; only the valid flags do
    local_mem_pkg::avl_cmd_t main_q;
    local_mem_pkg::avl_cmd_t skid_q;
    logic                    main_valid;
    logic                    skid_valid;

    logic in_valid;
    logic in_fire;
    logic out_fire;
    logic main_free;

    // ============================================================
    // Handshake decode
    // ============================================================

    assign in_valid = in_cmd.read | in_cmd.write;

    // Upstream is only stalled while the skid entry is occupied
    assign in_waitrequest = skid_valid;
    assign in_fire        = in_valid & ~skid_valid;

    // The main entry drains when downstream accepts it
    assign out_fire  = main_valid & ~out_waitrequest;

    // Main can take a new beat this edge if empty or draining
    assign main_free = ~main_valid | out_fire;

    // ============================================================
    // Entry control
    // ============================================================

    always_ff @(posedge tgt_mem_afu_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end
        else if (main_free)
        begin
            // Skid has priority so command order is preserved.
            // No new beat can arrive while skid is full
            if (skid_valid)
            begin
                main_valid <= 1'b1;
                skid_valid <= 1'b0;
            end
            else
            begin
                main_valid <= in_fire;
            end
        end
        else if (in_fire)
        begin
            // Downstream stalls and a beat arrives, so park it
            skid_valid <= 1'b1;
        end
    end

    // Payload movement mirrors the control decisions above
    always_ff @(posedge tgt_mem_afu_clk)
    begin
        if (main_free)
        begin
            main_q <= skid_valid ? skid_q : in_cmd;
        end
        else if (in_fire)
        begin
            skid_q <= in_cmd;
        end
    end

    // ============================================================
    // Output
    // ============================================================

    // The stored read/write bits are masked by the valid flag,
    // which keeps the output idle after reset
    always_comb
    begin
        out_cmd       = main_q;
        out_cmd.read  = main_q.read & main_valid;
        out_cmd.write = main_q.write & main_valid;
    end

endmodule

`default_nettype wire

//--- design/local_mem_bank.sv
// Single-port memory bank with Avalon-MM burst commands.
// Reads return after MEM_READ_LATENCY cycles with no response back-pressure.
// Array contents are not cleared by reset. Burst counts of 0 act as 1.

`default_nettype none

module local_mem_bank (
    input  logic                     tgt_mem_afu_clk,
    input  logic                     rst_n,

    input  local_mem_pkg::avl_cmd_t  cmd,
    output logic                     waitrequest,

    output local_mem_pkg::mem_data_t readdata,
    output logic                     readdatavalid
);

    localparam int DEPTH = 2 ** local_mem_pkg::MEM_ADDR_W;
    localparam int LAT   = local_mem_pkg::MEM_READ_LATENCY;

    local_mem_pkg::mem_data_t    mem_array [DEPTH];

    // Burst sequencer state
    local_mem_pkg::bank_state_t  state;
    local_mem_pkg::mem_burst_t   beats_left;
    local_mem_pkg::mem_addr_t    next_addr;

    // Decoded beat activity for this cycle
    local_mem_pkg::mem_burst_t   cmd_len;
    logic                        wr_beat;
    logic                        rd_accept;
    logic                        rd_issue;
    local_mem_pkg::mem_addr_t    wr_addr;
    local_mem_pkg::mem_addr_t    rd_addr;

    // Read data pipeline, one slot per cycle of latency
    local_mem_pkg::mem_data_t    rd_data_pipe [LAT];
    logic [LAT-1:0]              rd_valid_pipe;

    // Legal burst length for a command, clamped to 1..MEM_MAX_BURST
    function automatic local_mem_pkg::mem_burst_t burst_len(
        input local_mem_pkg::mem_burst_t bc
    );
        local_mem_pkg::mem_burst_t len;
        len = bc;
        if (bc == '0)
            len = local_mem_pkg::mem_burst_t'(1);
        else if (bc > local_mem_pkg::mem_burst_t'(local_mem_pkg::MEM_MAX_BURST))
            len = local_mem_pkg::mem_burst_t'(local_mem_pkg::MEM_MAX_BURST);
        return len;
    endfunction

    // ============================================================
    // Command decode
    // ============================================================

    // Only a read burst in progress blocks the command port
    assign waitrequest = (state == local_mem_pkg::BANK_RD_BURST);

    assign cmd_len   = burst_len(cmd.burstcount);
    assign wr_beat   = cmd.write & ~waitrequest;
    assign rd_accept = cmd.read & (state == local_mem_pkg::BANK_IDLE);

    // A read issues on its accept edge and on every burst cycle after it
    assign rd_issue = rd_accept | (state == local_mem_pkg::BANK_RD_BURST);

    // Later burst beats use the sequencer address, not the command field
    assign wr_addr = (state == local_mem_pkg::BANK_WR_BURST) ? next_addr : cmd.address;
    assign rd_addr = (state == local_mem_pkg::BANK_RD_BURST) ? next_addr : cmd.address;

    // ============================================================
    // Burst sequencer
    // ============================================================

    always_ff @(posedge tgt_mem_afu_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= local_mem_pkg::BANK_IDLE;
            beats_left <= '0;
            next_addr  <= '0;
        end
        else
        begin
            case (state)
                local_mem_pkg::BANK_IDLE:
                begin
                    // Single-beat commands never leave idle
                    if ((wr_beat || rd_accept) && cmd_len > local_mem_pkg::mem_burst_t'(1))
                    begin
                        state      <= wr_beat ? local_mem_pkg::BANK_WR_BURST
                                              : local_mem_pkg::BANK_RD_BURST;
                        beats_left <= cmd_len - local_mem_pkg::mem_burst_t'(1);
                        next_addr  <= cmd.address + local_mem_pkg::mem_addr_t'(1);
                    end
                end

                local_mem_pkg::BANK_WR_BURST,
                local_mem_pkg::BANK_RD_BURST:
                begin
                    // Write bursts advance per accepted beat, reads every cycle
                    if (wr_beat || state == local_mem_pkg::BANK_RD_BURST)
                    begin
                        beats_left <= beats_left - local_mem_pkg::mem_burst_t'(1);
                        next_addr  <= next_addr + local_mem_pkg::mem_addr_t'(1);
                        if (beats_left == local_mem_pkg::mem_burst_t'(1))
                            state <= local_mem_pkg::BANK_IDLE;
                    end
                end

                default:
                begin
                    state <= local_mem_pkg::BANK_IDLE;
                end
            endcase
        end
    end

    // ============================================================
    // Array and read pipeline
    // ============================================================

    // Writes merge the enabled bytes into the addressed word
    // The first read slot captures the word at the read address
    always_ff @(posedge tgt_mem_afu_clk)
    begin
        if (wr_beat)
        begin
            for (int b = 0; b < local_mem_pkg::MEM_BE_W; b++)
            begin
                if (cmd.byteenable[b])
                    mem_array[wr_addr][8*b +: 8] <= cmd.writedata[8*b +: 8];
            end
        end
        rd_data_pipe[0] <= mem_array[rd_addr];
        for (int s = 1; s < LAT; s++)
        begin
            rd_data_pipe[s] <= rd_data_pipe[s-1];
        end
    end

    // Valid bits shift alongside the data slots
    always_ff @(posedge tgt_mem_afu_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_valid_pipe <= '0;
        end
        else
        begin
            rd_valid_pipe[0] <= rd_issue;
            for (int s = 1; s < LAT; s++)
            begin
                rd_valid_pipe[s] <= rd_valid_pipe[s-1];
            end
        end
    end

    assign readdata      = rd_data_pipe[LAT-1];
    assign readdatavalid = rd_valid_pipe[LAT-1];

endmodule

`default_nettype wire

//--- design/local_mem_avalon_top.sv
// Local memory bank behind a chain of Avalon command register stages.
// Single clock domain, no clock crossing. Responses bypass the stages.
// With N_CMD_REG_STAGES at zero the AFU port connects straight to the bank.

`default_nettype none

module local_mem_avalon_top (
    input  logic                     tgt_mem_afu_clk,
    input  logic                     rst_n,

    // AFU-side Avalon-MM command port
    input  local_mem_pkg::avl_cmd_t  afu_cmd,
    output logic                     afu_waitrequest,

    // AFU-side response port, no back-pressure
    output local_mem_pkg::mem_data_t afu_readdata,
    output logic                     afu_readdatavalid
);

    localparam int N_STAGES = local_mem_pkg::N_CMD_REG_STAGES;

    // ============================================================
    // Command chain
    // ============================================================

    // Index 0 is the AFU port and index N_STAGES is the bank port.
    // Each waitrequest travels against the command direction
    wire local_mem_pkg::avl_cmd_t cmd_chain [N_STAGES+1];
    wire [N_STAGES:0]             wait_chain;

    assign cmd_chain[0]    = afu_cmd;
    assign afu_waitrequest = wait_chain[0];

    // Every stage honours waitrequest, so any count is safe
    for (genvar i = 0; i < N_STAGES; i++)
    begin : g_stage
        avalon_cmd_reg_stage u_stage (
            .tgt_mem_afu_clk (tgt_mem_afu_clk),
            .rst_n           (rst_n),
            .in_cmd          (cmd_chain[i]),
            .in_waitrequest  (wait_chain[i]),
            .out_cmd         (cmd_chain[i+1]),
            .out_waitrequest (wait_chain[i+1])
        );
    end

    // ============================================================
    // Memory bank
    // ============================================================

    local_mem_bank u_bank (
        .tgt_mem_afu_clk (tgt_mem_afu_clk),
        .rst_n           (rst_n),
        .cmd             (cmd_chain[N_STAGES]),
        .waitrequest     (wait_chain[N_STAGES]),
        .readdata        (afu_readdata),
        .readdatavalid   (afu_readdatavalid)
    );

endmodule

`default_nettype wire

//--- tests/local_mem_avalon_props.sv
// Avalon protocol checks on the AFU port of local_mem_avalon_top.
// Bound into every instance of the top level

`default_nettype none

module local_mem_avalon_props (
    input  logic                    tgt_mem_afu_clk,
    input  logic                    rst_n,
    input  local_mem_pkg::avl_cmd_t afu_cmd,
    input  logic                    afu_waitrequest,
    input  logic                    afu_readdatavalid
);

    timeunit 1ns;
    timeprecision 1ps;

    // Shortest path from a command to its first readdatavalid
    localparam int QUIET = local_mem_pkg::N_CMD_REG_STAGES + local_mem_pkg::MEM_READ_LATENCY;

    // Cycles since reset release, saturates once the quiet window is over
    int unsigned settle_cnt;

    always_ff @(posedge tgt_mem_afu_clk or negedge rst_n)
    begin
        if (!rst_n)
            settle_cnt <= 0;
        else if (settle_cnt < QUIET)
            settle_cnt <= settle_cnt + 1;
    end

    a_reset_quiet: assert property (@(posedge tgt_mem_afu_clk)
        !rst_n |-> !afu_waitrequest && !afu_readdatavalid)
        else $error("afu_waitrequest or afu_readdatavalid high during reset");

    a_rw_exclusive: assert property (@(posedge tgt_mem_afu_clk) disable iff (!rst_n)
        !(afu_cmd.read && afu_cmd.write))
        else $error("afu_cmd has read and write set together");

    // A stalled beat may not change until the port takes it
    a_stall_stable: assert property (@(posedge tgt_mem_afu_clk) disable iff (!rst_n)
        (afu_cmd.read || afu_cmd.write) && afu_waitrequest |=> $stable(afu_cmd))
        else $error("afu_cmd changed while afu_waitrequest was high");

    a_no_early_rdv: assert property (@(posedge tgt_mem_afu_clk)
        rst_n && settle_cnt < QUIET |-> !afu_readdatavalid)
        else $error("afu_readdatavalid too soon after reset release");

endmodule

bind local_mem_avalon_top local_mem_avalon_props u_props (
    .tgt_mem_afu_clk   (tgt_mem_afu_clk),
    .rst_n             (rst_n),
    .afu_cmd           (afu_cmd),
    .afu_waitrequest   (afu_waitrequest),
    .afu_readdatavalid (afu_readdatavalid)
);

`default_nettype wire

//--- tests/local_mem_avalon_tb.sv
// Self-checking testbench for the local memory bank behind the Avalon command stages.
// The whole array is written with an address pattern first, so no read returns X.
// Inputs change on the rising edge; waitrequest and read data are sampled on the falling edge.

`default_nettype none

module local_mem_avalon_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH       = 2 ** local_mem_pkg::MEM_ADDR_W;
    localparam int HOLD_LIMIT  = 50;
    localparam int DRAIN_LIMIT = 200;
    localparam int SETTLE      = local_mem_pkg::N_CMD_REG_STAGES + local_mem_pkg::MEM_READ_LATENCY;

    // Kinds of write data for write_burst
    localparam int WR_FULL    = 0;
    localparam int WR_PARTIAL = 1;
    localparam int WR_FILL    = 2;

    localparam logic [31:0] LFSR_SEED = 32'h43064b0f;
    localparam logic [31:0] LFSR_TAPS = 32'hB4BCD35C;

    logic                     tgt_mem_afu_clk;
    logic                     rst_n;
    local_mem_pkg::avl_cmd_t  afu_cmd;
    logic                     afu_waitrequest;
    local_mem_pkg::mem_data_t afu_readdata;
    logic                     afu_readdatavalid;

    // Shadow of the bank contents and the words still owed by the DUT
    local_mem_pkg::mem_data_t shadow [DEPTH];
    local_mem_pkg::mem_data_t expected_q [$];
    logic [31:0]              lfsr_state;

    local_mem_avalon_top dut (
        .tgt_mem_afu_clk   (tgt_mem_afu_clk),
        .rst_n             (rst_n),
        .afu_cmd           (afu_cmd),
        .afu_waitrequest   (afu_waitrequest),
        .afu_readdata      (afu_readdata),
        .afu_readdatavalid (afu_readdatavalid)
    );

    // ============================================================
    // Helpers
    // ============================================================

    // Right-shifting Galois LFSR, one step per random bit
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v          = {v[62:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // Expected word after a write: enabled bytes come from the new data
    function automatic local_mem_pkg::mem_data_t merge_bytes(
        input local_mem_pkg::mem_data_t old_word,
        input local_mem_pkg::mem_data_t new_word,
        input local_mem_pkg::mem_be_t   be
    );
        local_mem_pkg::mem_data_t merged;
        merged = old_word;
        for (int b = 0; b < local_mem_pkg::MEM_BE_W; b++)
        begin
            if (be[b])
                merged[8*b +: 8] = new_word[8*b +: 8];
        end
        return merged;
    endfunction

    // Initial contents, every address bit shows up twice
    function automatic local_mem_pkg::mem_data_t fill_word(input local_mem_pkg::mem_addr_t a);
        return {16'hC0DE, 6'd0, a, 6'd0, ~a, 16'h5A5A};
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected)
            fail_run($sformatf("Mismatch at %0d ns: %s expected 0x%h, actual 0x%h",
                               $time, name, expected, actual));
    endtask

    // Called just after a rising edge; returns on the edge that transfers the beat
    task automatic send_beat(input local_mem_pkg::avl_cmd_t c);
        int unsigned waited;
        waited = 0;
        afu_cmd <= c;
        @(negedge tgt_mem_afu_clk);
        while (afu_waitrequest && waited < HOLD_LIMIT)
        begin
            waited++;
            @(negedge tgt_mem_afu_clk);
        end
        if (afu_waitrequest)
            fail_run($sformatf("afu_waitrequest stayed high for %0d cycles", HOLD_LIMIT));
        else
            @(posedge tgt_mem_afu_clk);
    endtask

    task automatic idle_cycles(input int n);
        if (n > 0)
        begin
            afu_cmd <= '0;
            repeat (n) @(posedge tgt_mem_afu_clk);
        end
    endtask

    // Only the first beat carries address and count, later ones leave them zero
    task automatic write_burst(input local_mem_pkg::mem_addr_t addr, input int len,
                               input int kind);
        local_mem_pkg::avl_cmd_t  c;
        local_mem_pkg::mem_addr_t a;
        local_mem_pkg::mem_data_t d;
        local_mem_pkg::mem_be_t   be;
        for (int i = 0; i < len; i++)
        begin
            a  = addr + local_mem_pkg::mem_addr_t'(i);
            d  = (kind == WR_FILL) ? fill_word(a) : rand_bits(64);
            be = (kind == WR_PARTIAL) ? local_mem_pkg::mem_be_t'(rand_bits(8)) : '1;
            c            = '0;
            c.write      = 1'b1;
            c.writedata  = d;
            c.byteenable = be;
            if (i == 0)
            begin
                c.address    = addr;
                c.burstcount = local_mem_pkg::mem_burst_t'(len);
            end
            send_beat(c);
            shadow[a] = merge_bytes(shadow[a], d, be);
        end
    endtask

    // Expected words are captured from the shadow at the moment of acceptance
    task automatic read_burst(input local_mem_pkg::mem_addr_t addr, input int len);
        local_mem_pkg::avl_cmd_t c;
        c            = '0;
        c.read       = 1'b1;
        c.address    = addr;
        c.burstcount = local_mem_pkg::mem_burst_t'(len);
        send_beat(c);
        for (int i = 0; i < len; i++)
        begin
            expected_q.push_back(shadow[addr + local_mem_pkg::mem_addr_t'(i)]);
        end
    endtask

    task automatic wait_drain();
        int unsigned waited;
        waited = 0;
        afu_cmd <= '0;
        while (expected_q.size() != 0 && waited < DRAIN_LIMIT)
        begin
            waited++;
            @(posedge tgt_mem_afu_clk);
        end
        if (expected_q.size() != 0)
            fail_run($sformatf("no readdatavalid within %0d cycles", DRAIN_LIMIT));
    endtask

    // ============================================================
    // Clock and response checker
    // ============================================================

    initial
    begin
        tgt_mem_afu_clk = 1'b0;
        forever
        begin
            #50 tgt_mem_afu_clk = ~tgt_mem_afu_clk;
        end
    end

    // Every readdatavalid pulse consumes exactly one expected word
    initial
    begin : response_checker
        local_mem_pkg::mem_data_t exp_word;
        forever
        begin
            @(negedge tgt_mem_afu_clk);
            if (afu_readdatavalid === 1'b1)
            begin
                if (expected_q.size() == 0)
                begin
                    fail_run("readdatavalid arrived with no read outstanding");
                end
                else
                begin
                    exp_word = expected_q.pop_front();
                    check_value("afu_readdata", exp_word, afu_readdata);
                end
            end
        end
    end

    // ============================================================
    // Stimulus
    // ============================================================

    initial
    begin : stimulus
        local_mem_pkg::mem_addr_t addr;
        int                       len;
        lfsr_state      = LFSR_SEED;
        rst_n           = 1'b0;
        afu_cmd         = '0;
        repeat (3) @(posedge tgt_mem_afu_clk);
        rst_n <= 1'b1;

        // Port must be quiet before the first command
        @(negedge tgt_mem_afu_clk);
        check_value("afu_waitrequest", 64'd0, 64'(afu_waitrequest));
        check_value("afu_readdatavalid", 64'd0, 64'(afu_readdatavalid));
        @(posedge tgt_mem_afu_clk);

        for (int base = 0; base < DEPTH; base += local_mem_pkg::MEM_MAX_BURST)
            write_burst(local_mem_pkg::mem_addr_t'(base), local_mem_pkg::MEM_MAX_BURST, WR_FILL);

        // Single write then read, with and without byte enables
        for (int i = 0; i < 12; i++)
        begin
            addr = local_mem_pkg::mem_addr_t'(rand_bits(local_mem_pkg::MEM_ADDR_W));
            write_burst(addr, 1, (i < 4) ? WR_FULL : WR_PARTIAL);
            idle_cycles(int'(rand_bits(2)));
            read_burst(addr, 1);
        end
        wait_drain();

        // Write bursts read back over the same range
        for (int i = 0; i < 16; i++)
        begin
            addr = local_mem_pkg::mem_addr_t'(rand_bits(local_mem_pkg::MEM_ADDR_W));
            len  = 1 + int'(rand_bits(3));
            write_burst(addr, len, WR_FULL);
            idle_cycles(int'(rand_bits(2)));
            read_burst(addr, len);
            idle_cycles(int'(rand_bits(2)));
        end
        wait_drain();

        // Back-to-back mixed traffic with no idle cycles
        for (int i = 0; i < 300; i++)
        begin
            addr = local_mem_pkg::mem_addr_t'(rand_bits(local_mem_pkg::MEM_ADDR_W));
            len  = 1 + int'(rand_bits(3));
            case (int'(rand_bits(2)))
                0: read_burst(addr, len);
                1: read_burst(addr, 1);
                2: write_burst(addr, len, WR_PARTIAL);
                default: write_burst(addr, 1, WR_FULL);
            endcase
        end
        wait_drain();

        // Read right behind a write to the same word
        for (int i = 0; i < 16; i++)
        begin
            addr = local_mem_pkg::mem_addr_t'(rand_bits(local_mem_pkg::MEM_ADDR_W));
            write_burst(addr, 1, WR_PARTIAL);
            read_burst(addr, 1);
        end
        wait_drain();

        // Extra time lets a duplicated beat reach the response checker
        idle_cycles(2 * SETTLE + 4);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
design/local_mem_pkg.sv
design/avalon_cmd_reg_stage.sv
design/local_mem_bank.sv
design/local_mem_avalon_top.sv
tests/local_mem_avalon_props.sv
tests/local_mem_avalon_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the local memory testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE="$BUILD_DIR/sim.log"

if ! mkdir -p "$BUILD_DIR"; then
    echo "could not create $BUILD_DIR"
    exit 1
fi

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module local_mem_avalon_tb \
        -Mdir "$BUILD_DIR/obj_dir" -o local_mem_avalon_sim \
        -f compile.f; then
    echo "Verilator build failed"
    exit 1
fi

"$BUILD_DIR/obj_dir/local_mem_avalon_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -q "STATUS: FAIL" "$LOG_FILE"; then
    echo "simulation failed, see $LOG_FILE"
    exit 1
fi

if [ "$sim_status" -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

echo "simulation passed"
exit 0
